// File: bench/cpu_tb.sv
// Testbench for cpu_top: loads a random program, replays it on a reference model and checks each retire
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

	localparam int PROG_LEN = 200;
	// Load under reset, 2 more reset cycles, then 5 cycles per instruction with margin
	localparam int WATCHDOG_CYCLES = PROG_LEN + 3 + PROG_LEN * 5 + 100;
	localparam int T_RESET = 0;
	localparam int T_RR    = 1;
	localparam int T_IMM   = 2;
	localparam int T_CTRL  = 3;
	localparam int T_HALT  = 4;

	// One expected retire, tagged with the test it belongs to
	typedef struct packed {
		word_t    pc;
		logic     write;
		reg_sel_t rg;
		word_t    data;
		int       test_id;
	} retire_rec_t;

	logic     clk;
	logic     rst;
	logic     imem_wr_en;
	word_t    imem_wr_addr;
	instr_t   imem_wr_data;
	logic     retire_valid;
	word_t    retire_pc;
	logic     retire_write;
	reg_sel_t retire_reg;
	word_t    retire_data;
	logic     halted;

	instr_t      prog [PROG_LEN];
	retire_rec_t expected_q [$];
	int          checks [5] = '{default: 0};
	int          errors [5] = '{default: 0};
	string       test_names [5] = '{"reset", "rr_alu", "imm_ops", "control_flow", "halt"};
	int          retire_count = 0;
	int          model_count = 0;

	cpu_top #(.IMEM_DEPTH(256), .BUF_DEPTH(2)) uut (
		.clk          (clk),
		.rst          (rst),
		.imem_wr_en   (imem_wr_en),
		.imem_wr_addr (imem_wr_addr),
		.imem_wr_data (imem_wr_data),
		.retire_valid (retire_valid),
		.retire_pc    (retire_pc),
		.retire_write (retire_write),
		.retire_reg   (retire_reg),
		.retire_data  (retire_data),
		.halted       (halted)
	);

	initial clk = 1'b0;
	// 4 ns period
	always #2 clk = ~clk;

	task automatic check_value(input int test_id, input string what, input word_t expected,
			input word_t actual);
		checks[test_id]++;
		if (actual !== expected) begin
			errors[test_id]++;
			$display("[ERROR] %s %s: expected %h, actual %h", test_names[test_id], what,
				expected, actual);
		end
	endtask

	task automatic report_test(input int test_id);
		$display("%-13s %0d checks, %0d errors", test_names[test_id], checks[test_id],
			errors[test_id]);
	endtask

	function automatic instr_t random_instr(input int idx);
		int         kind;
		int         room;
		int         k;
		logic [4:0] op;
		logic [7:0] imm8;
		kind = $urandom_range(0, 9);
		// Largest forward skip that still lands on or before the final HALT
		room = PROG_LEN - 2 - idx;
		if (room < 1 && (kind == 7 || kind == 8))
			kind = 9;
		k = $urandom_range(1, (room < 8) ? room : 8);
		case (kind)
			0, 1, 2: return {OP_RR_ALU, 3'($urandom), 3'($urandom), 3'($urandom), 2'($urandom)};
			3, 4, 5: begin
				// ADDI, SUBI, XORI and ANDNI are consecutive codes
				op = OP_ADDI | 5'($urandom_range(0, 3));
				return {op, 3'($urandom), 3'($urandom), 5'($urandom)};
			end
			6: begin
				op = ($urandom_range(0, 1) == 0) ? OP_LBI : OP_SLBI;
				// Zero now and then so BEQZ gets taken
				imm8 = ($urandom_range(0, 3) == 0) ? 8'h00 : 8'($urandom);
				return {op, 3'($urandom), imm8};
			end
			7: begin
				op = ($urandom_range(0, 1) == 0) ? OP_BEQZ : OP_BNEZ;
				return {op, 3'($urandom), 8'(2 * k)};
			end
			8: return {OP_J, 11'(2 * k)};
			default: return {OP_NOP, 11'($urandom)};
		endcase
	endfunction

	// Instruction-level model, walks the program and queues the expected retires
	task automatic run_model();
		word_t       regs [8];
		word_t       pc;
		word_t       next_pc;
		instr_t      ins;
		logic [4:0]  op;
		word_t       a;
		word_t       b;
		word_t       se5;
		word_t       ze5;
		word_t       se8;
		retire_rec_t rec;
		logic        done;
		for (int i = 0; i < 8; i++)
			regs[i] = '0;
		pc = '0;
		done = 1'b0;
		while (!done && expected_q.size() < PROG_LEN) begin
			ins = prog[pc[8:1]];
			op = ins[15:11];
			a = regs[ins[10:8]];
			b = regs[ins[7:5]];
			se5 = {{11{ins[4]}}, ins[4:0]};
			ze5 = {11'b0, ins[4:0]};
			se8 = {{8{ins[7]}}, ins[7:0]};
			rec = '{pc: pc, write: 1'b0, rg: '0, data: '0, test_id: T_CTRL};
			next_pc = pc + 16'd2;
			case (op)
				OP_RR_ALU: begin
					rec.write = 1'b1;
					rec.rg = ins[4:2];
					rec.test_id = T_RR;
					case (ins[1:0])
						2'b00:   rec.data = a + b;
						2'b01:   rec.data = b - a;
						2'b10:   rec.data = a ^ b;
						default: rec.data = a & ~b;
					endcase
				end
				OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
					rec.write = 1'b1;
					rec.rg = ins[7:5];
					rec.test_id = T_IMM;
					case (op)
						OP_ADDI: rec.data = a + se5;
						OP_SUBI: rec.data = se5 - a;
						OP_XORI: rec.data = a ^ ze5;
						default: rec.data = a & ~ze5;
					endcase
				end
				OP_LBI, OP_SLBI: begin
					rec.write = 1'b1;
					rec.rg = ins[10:8];
					rec.test_id = T_IMM;
					rec.data = (op == OP_LBI) ? se8 : ((a << 8) | {8'h00, ins[7:0]});
				end
				OP_BEQZ: if (a == '0) next_pc = pc + 16'd2 + se8;
				OP_BNEZ: if (a != '0) next_pc = pc + 16'd2 + se8;
				OP_J:    next_pc = pc + 16'd2 + {{5{ins[10]}}, ins[10:0]};
				OP_HALT: begin
					rec.test_id = T_HALT;
					done = 1'b1;
				end
				default: ;
			endcase
			if (rec.write)
				regs[rec.rg] = rec.data;
			expected_q.push_back(rec);
			pc = next_pc;
		end
		model_count = expected_q.size();
	endtask

	// Retire checker, outputs are stable at the falling edge
	always @(negedge clk) begin
		retire_rec_t rec;
		if (retire_valid === 1'b1) begin
			retire_count++;
			if (expected_q.size() == 0) begin
				errors[T_HALT]++;
				$display("Retire at pc %h after the program should have halted", retire_pc);
			end else begin
				rec = expected_q.pop_front();
				check_value(T_CTRL, "retire_pc", rec.pc, retire_pc);
				check_value(rec.test_id, "retire_write", 16'(rec.write), 16'(retire_write));
				if (rec.write)
					check_value(rec.test_id, "retire_reg", 16'(rec.rg), 16'(retire_reg));
				check_value(rec.test_id, "retire_data", rec.data, retire_data);
				if (rec.test_id == T_HALT)
					check_value(T_HALT, "halted at retire", 16'd1, 16'(halted));
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the program never halted", WATCHDOG_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		int total_checks;
		int total_errors;
		void'($urandom(32'hd1d99578));
		rst = 1'b1;
		imem_wr_en = 1'b0;
		imem_wr_addr = '0;
		imem_wr_data = '0;
		for (int i = 0; i < PROG_LEN - 1; i++)
			prog[i] = random_instr(i);
		prog[PROG_LEN - 1] = {OP_HALT, 11'b0};
		run_model();

		// Program goes in while reset holds the core
		for (int i = 0; i < PROG_LEN; i++) begin
			@(posedge clk);
			imem_wr_en <= 1'b1;
			imem_wr_addr <= 16'(i);
			imem_wr_data <= prog[i];
		end
		@(posedge clk);
		imem_wr_en <= 1'b0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		@(posedge clk);
		@(negedge clk);
		check_value(T_RESET, "retire_valid", 16'd0, 16'(retire_valid));
		check_value(T_RESET, "halted", 16'd0, 16'(halted));
		report_test(T_RESET);

		while (halted !== 1'b1)
			@(negedge clk);
		@(posedge clk);
		report_test(T_RR);
		report_test(T_IMM);
		report_test(T_CTRL);

		// Quiet window, nothing may retire after HALT
		repeat (10) @(negedge clk);
		check_value(T_HALT, "halted stays high", 16'd1, 16'(halted));
		check_value(T_HALT, "retire count", 16'(model_count), 16'(retire_count));
		report_test(T_HALT);

		total_checks = 0;
		total_errors = 0;
		for (int t = 0; t < 5; t++) begin
			total_checks += checks[t];
			total_errors += errors[t];
		end
		$display("Tests: 5, checks: %0d, errors: %0d", total_checks, total_errors);
		if (total_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: rtl/alu.sv
// Combinational ALU for the execute unit, a is Rs and b is Rt or the immediate
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
	input  word_t   a,
	input  word_t   b,
	input  alu_op_e op,
	output word_t   result
);

	always_comb begin
		case (op)
			ALU_ADD:  result = a + b;
			// Inverted-input subtract, b minus a
			ALU_SUB:  result = b - a;
			ALU_XOR:  result = a ^ b;
			ALU_ANDN: result = a & ~b;
			ALU_PASS_B: result = b;
			// SLBI: low byte of a moves up, immediate fills the bottom
			ALU_SHIFT_LOAD: result = (a << 8) | b;
			default:  result = b;
		endcase
	end

endmodule

// File: rtl/cpu_pkg.sv
// Shared widths, opcode encodings and ALU operations, imported by every core module and the testbench
package cpu_pkg;

	// Data word or program counter
	typedef logic [15:0] word_t;

	// Raw instruction word
	typedef logic [15:0] instr_t;

	// Register number
	typedef logic [2:0] reg_sel_t;

	// Bytes per instruction
	localparam word_t PC_STEP = 16'd2;

	// Opcode field, instruction bits 15 to 11
	typedef enum logic [4:0] {
		OP_HALT   = 5'b00000,
		OP_NOP    = 5'b00001,
		OP_J      = 5'b00100,
		OP_ADDI   = 5'b01000,
		OP_SUBI   = 5'b01001,
		OP_XORI   = 5'b01010,
		OP_ANDNI  = 5'b01011,
		OP_BEQZ   = 5'b01100,
		OP_BNEZ   = 5'b01101,
		OP_SLBI   = 5'b10010,
		OP_LBI    = 5'b11000,
		OP_RR_ALU = 5'b11011
	} opcode_e;

	// ALU operations
	// SUB is b minus a, ANDN is a and not b
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_XOR,
		ALU_ANDN,
		ALU_PASS_B,
		ALU_SHIFT_LOAD
	} alu_op_e;

endpackage

// File: rtl/cpu_top.sv
// Core top level joining fetch, instruction buffer and execute, with the memory loader and retire trace
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
	parameter int IMEM_DEPTH = 256,
	parameter int BUF_DEPTH  = 2
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     imem_wr_en,
	input  word_t    imem_wr_addr,
	input  instr_t   imem_wr_data,
	output logic     retire_valid,
	output word_t    retire_pc,
	output logic     retire_write,
	output reg_sel_t retire_reg,
	output word_t    retire_data,
	output logic     halted
);

	logic   f_valid;
	logic   f_ready;
	instr_t f_instr;
	word_t  f_pc;
	logic   b_valid;
	logic   b_ready;
	instr_t b_instr;
	word_t  b_pc;
	logic   redirect;
	word_t  redirect_pc;

	fetch_unit #(.IMEM_DEPTH(IMEM_DEPTH)) fetch0 (
		.clk          (clk),
		.rst          (rst),
		.imem_wr_en   (imem_wr_en),
		.imem_wr_addr (imem_wr_addr),
		.imem_wr_data (imem_wr_data),
		.redirect     (redirect),
		.redirect_pc  (redirect_pc),
		.f_ready      (f_ready),
		.f_valid      (f_valid),
		.f_instr      (f_instr),
		.f_pc         (f_pc)
	);

	// A taken branch also empties the queue
	instr_buffer #(.BUF_DEPTH(BUF_DEPTH)) buf0 (
		.clk     (clk),
		.rst     (rst),
		.flush   (redirect),
		.f_valid (f_valid),
		.f_instr (f_instr),
		.f_pc    (f_pc),
		.b_ready (b_ready),
		.f_ready (f_ready),
		.b_valid (b_valid),
		.b_instr (b_instr),
		.b_pc    (b_pc)
	);

	exec_unit exec0 (
		.clk          (clk),
		.rst          (rst),
		.b_valid      (b_valid),
		.b_instr      (b_instr),
		.b_pc         (b_pc),
		.b_ready      (b_ready),
		.redirect     (redirect),
		.redirect_pc  (redirect_pc),
		.retire_valid (retire_valid),
		.retire_pc    (retire_pc),
		.retire_write (retire_write),
		.retire_reg   (retire_reg),
		.retire_data  (retire_data),
		.halted       (halted)
	);

endmodule

// File: rtl/decoder.sv
// Instruction decode: register selects, destination, extended immediate and control flags
`timescale 1ns/1ps

module decoder import cpu_pkg::*; (
	input  instr_t   instr,
	output opcode_e  opcode,
	output reg_sel_t rs_sel,
	output reg_sel_t rt_sel,
	output reg_sel_t wr_sel,
	output logic     wr_en,
	output alu_op_e  alu_op,
	output logic     use_imm,
	output word_t    imm,
	output logic     is_branch,
	output logic     branch_if_zero,
	output logic     is_jump,
	output logic     is_halt
);

	logic [4:0]  op_bits;
	logic [4:0]  imm5;
	logic [7:0]  imm8;
	logic [10:0] disp11;
	logic [1:0]  funct;
	reg_sel_t    rd_sel;
	logic        known;

	assign op_bits = instr[15:11];
	assign rs_sel  = instr[10:8];
	assign rt_sel  = instr[7:5];
	assign rd_sel  = instr[4:2];
	assign imm5    = instr[4:0];
	assign imm8    = instr[7:0];
	assign disp11  = instr[10:0];
	assign funct   = instr[1:0];

	// Anything outside the kept set behaves as NOP
	assign opcode = known ? opcode_e'(op_bits) : OP_NOP;

	always_comb begin
		known          = 1'b1;
		wr_sel         = rt_sel;
		wr_en          = 1'b0;
		alu_op         = ALU_ADD;
		use_imm        = 1'b0;
		imm            = '0;
		is_branch      = 1'b0;
		branch_if_zero = 1'b0;
		is_jump        = 1'b0;
		is_halt        = 1'b0;
		case (op_bits)
			OP_HALT: is_halt = 1'b1;
			OP_NOP:  known = 1'b1;
			OP_J: begin
				is_jump = 1'b1;
				imm     = {{5{disp11[10]}}, disp11};
			end
			OP_ADDI, OP_SUBI: begin
				wr_en   = 1'b1;
				use_imm = 1'b1;
				imm     = {{11{imm5[4]}}, imm5};
				alu_op  = op_bits[0] ? ALU_SUB : ALU_ADD;
			end
			// Logical immediates are zero extended
			OP_XORI, OP_ANDNI: begin
				wr_en   = 1'b1;
				use_imm = 1'b1;
				imm     = {11'b0, imm5};
				alu_op  = op_bits[0] ? ALU_ANDN : ALU_XOR;
			end
			OP_BEQZ, OP_BNEZ: begin
				is_branch      = 1'b1;
				branch_if_zero = ~op_bits[0];
				imm            = {{8{imm8[7]}}, imm8};
			end
			OP_LBI: begin
				wr_sel  = rs_sel;
				wr_en   = 1'b1;
				use_imm = 1'b1;
				imm     = {{8{imm8[7]}}, imm8};
				alu_op  = ALU_PASS_B;
			end
			OP_SLBI: begin
				wr_sel  = rs_sel;
				wr_en   = 1'b1;
				use_imm = 1'b1;
				imm     = {8'h00, imm8};
				alu_op  = ALU_SHIFT_LOAD;
			end
			OP_RR_ALU: begin
				wr_sel = rd_sel;
				wr_en  = 1'b1;
				case (funct)
					2'b00:   alu_op = ALU_ADD;
					2'b01:   alu_op = ALU_SUB;
					2'b10:   alu_op = ALU_XOR;
					default: alu_op = ALU_ANDN;
				endcase
			end
			default: known = 1'b0;
		endcase
	end

endmodule

// File: rtl/exec_unit.sv
// Execute stage: decodes the buffer head, writes back, resolves control flow and records each retire
`timescale 1ns/1ps

module exec_unit import cpu_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     b_valid,
	input  instr_t   b_instr,
	input  word_t    b_pc,
	output logic     b_ready,
	output logic     redirect,
	output word_t    redirect_pc,
	output logic     retire_valid,
	output word_t    retire_pc,
	output logic     retire_write,
	output reg_sel_t retire_reg,
	output word_t    retire_data,
	output logic     halted
);

	reg_sel_t rs_sel;
	reg_sel_t rt_sel;
	reg_sel_t wr_sel;
	logic     dec_wr_en;
	alu_op_e  alu_op;
	logic     use_imm;
	word_t    imm;
	logic     is_branch;
	logic     branch_if_zero;
	logic     is_jump;
	logic     is_halt;
	word_t    rs_data;
	word_t    rt_data;
	word_t    alu_b;
	word_t    alu_result;
	logic     accept;
	logic     commit;
	logic     taken;

	assign b_ready = ~halted;
	assign accept  = b_valid & b_ready;
	assign commit  = accept & dec_wr_en;
	assign alu_b   = use_imm ? imm : rt_data;

	// Branches test Rs against zero
	assign taken       = is_jump | (is_branch & ((rs_data == '0) == branch_if_zero));
	assign redirect    = accept & taken;
	assign redirect_pc = b_pc + PC_STEP + imm;

	decoder dec0 (
		.instr          (b_instr),
		.opcode         (),
		.rs_sel         (rs_sel),
		.rt_sel         (rt_sel),
		.wr_sel         (wr_sel),
		.wr_en          (dec_wr_en),
		.alu_op         (alu_op),
		.use_imm        (use_imm),
		.imm            (imm),
		.is_branch      (is_branch),
		.branch_if_zero (branch_if_zero),
		.is_jump        (is_jump),
		.is_halt        (is_halt)
	);

	// Write lands at the accept edge, so the next instruction sees it
	reg_file rf0 (
		.clk      (clk),
		.rst      (rst),
		.rd1_sel  (rs_sel),
		.rd2_sel  (rt_sel),
		.wr_sel   (wr_sel),
		.wr_en    (commit),
		.wr_data  (alu_result),
		.rd1_data (rs_data),
		.rd2_data (rt_data)
	);

	alu alu0 (
		.a      (rs_data),
		.b      (alu_b),
		.op     (alu_op),
		.result (alu_result)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			retire_valid <= 1'b0;
			halted       <= 1'b0;
		end else begin
			retire_valid <= accept;
			if (accept & is_halt)
				halted <= 1'b1;
		end
	end

	// Retire record
	always_ff @(posedge clk) begin
		if (accept) begin
			retire_pc    <= b_pc;
			retire_write <= dec_wr_en;
			retire_reg   <= wr_sel;
			retire_data  <= dec_wr_en ? alu_result : '0;
		end
	end

endmodule

// File: rtl/fetch_unit.sv
// Instruction fetch: PC, loadable instruction memory and registered valid/ready output to the buffer
`timescale 1ns/1ps

module fetch_unit import cpu_pkg::*; #(
	parameter int IMEM_DEPTH = 256
) (
	input  logic   clk,
	input  logic   rst,
	input  logic   imem_wr_en,
	input  word_t  imem_wr_addr,
	input  instr_t imem_wr_data,
	input  logic   redirect,
	input  word_t  redirect_pc,
	input  logic   f_ready,
	output logic   f_valid,
	output instr_t f_instr,
	output word_t  f_pc
);

	localparam int AW = $clog2(IMEM_DEPTH);

	instr_t imem [IMEM_DEPTH];
	word_t  pc;
	logic   load;

	// Output register empty or being taken this cycle
	assign load = ~f_valid | f_ready;

	// Loader port, word addressed
	always_ff @(posedge clk) begin
		if (imem_wr_en)
			imem[imem_wr_addr[AW-1:0]] <= imem_wr_data;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc      <= '0;
			f_valid <= 1'b0;
		end else if (redirect) begin
			// Drop whatever was fetched down the wrong path
			pc      <= redirect_pc;
			f_valid <= 1'b0;
		end else if (load) begin
			pc      <= pc + PC_STEP;
			f_valid <= 1'b1;
		end
	end

	// Byte PC, so bit 0 is ignored and the index wraps
	always_ff @(posedge clk) begin
		if (~redirect & load) begin
			f_instr <= imem[pc[AW:1]];
			f_pc    <= pc;
		end
	end

endmodule

// File: rtl/instr_buffer.sv
// Circular instruction queue between fetch and execute, flushed on a taken branch or jump
`timescale 1ns/1ps

module instr_buffer import cpu_pkg::*; #(
	parameter int BUF_DEPTH = 2
) (
	input  logic   clk,
	input  logic   rst,
	input  logic   flush,
	input  logic   f_valid,
	input  instr_t f_instr,
	input  word_t  f_pc,
	input  logic   b_ready,
	output logic   f_ready,
	output logic   b_valid,
	output instr_t b_instr,
	output word_t  b_pc
);

	localparam int PW = $clog2(BUF_DEPTH);

	instr_t         buf_instr [BUF_DEPTH];
	word_t          buf_pc [BUF_DEPTH];
	logic [PW-1:0]  rd_ptr;
	logic [PW-1:0]  wr_ptr;
	logic [PW:0]    count;
	logic           push;
	logic           pop;

	assign f_ready = (count != (PW+1)'(BUF_DEPTH));
	assign b_valid = (count != '0);
	assign b_instr = buf_instr[rd_ptr];
	assign b_pc    = buf_pc[rd_ptr];

	assign push = f_valid & f_ready;
	assign pop  = b_valid & b_ready;

	always_ff @(posedge clk) begin
		if (rst | flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Push and pop together leave the count alone
			if (push & ~pop)
				count <= count + 1'b1;
			else if (pop & ~push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push & ~flush) begin
			buf_instr[wr_ptr] <= f_instr;
			buf_pc[wr_ptr]    <= f_pc;
		end
	end

endmodule

// File: rtl/reg_file.sv
// Eight 16-bit general registers, two asynchronous read ports and one synchronous write port
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  reg_sel_t rd1_sel,
	input  reg_sel_t rd2_sel,
	input  reg_sel_t wr_sel,
	input  logic     wr_en,
	input  word_t    wr_data,
	output word_t    rd1_data,
	output word_t    rd2_data
);

	word_t regs [8];

	assign rd1_data = regs[rd1_sel];
	assign rd2_data = regs[rd2_sel];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_sel] <= wr_data;
		end
	end

endmodule

// File: src.f
rtl/cpu_pkg.sv
rtl/fetch_unit.sv
rtl/instr_buffer.sv
rtl/decoder.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/exec_unit.sv
rtl/cpu_top.sv
bench/cpu_tb.sv
